/* filelist.f */
verilog/exp_pkg.sv
verilog/exp_ctrl_if.sv
verilog/exp_lut_rom.sv
verilog/exp_controller.sv
verilog/exp_datapath.sv
verilog/fixed_point_exp.sv
tb/tb_fixed_point_exp.sv

/* Bender.yml */
package:
  name: fixed_point_exp

sources:
  - verilog/exp_pkg.sv
  - verilog/exp_ctrl_if.sv
  - verilog/exp_lut_rom.sv
  - verilog/exp_controller.sv
  - verilog/exp_datapath.sv
  - verilog/fixed_point_exp.sv
  - target: test
    files:
      - tb/tb_fixed_point_exp.sv

/* exp_lut_1.mem */
// e^(-k) for k = 0..15, one Q10.22 word per line in binary
00000000_01000000_00000000_00000000
00000000_00010111_10001011_01010110
00000000_00001000_10101001_01010101
00000000_00000011_00101111_10110110
00000000_00000001_00101100_00010101
00000000_00000000_01101110_01100101
00000000_00000000_00101000_10011101
00000000_00000000_00001110_11110001
00000000_00000000_00000101_01111111
00000000_00000000_00000010_00000110
00000000_00000000_00000000_10111110
00000000_00000000_00000000_01000110
00000000_00000000_00000000_00011010
00000000_00000000_00000000_00001001
00000000_00000000_00000000_00000011
00000000_00000000_00000000_00000001

/* exp_lut_2.mem */
// e^(-k/8) for k = 0..7, one Q10.22 word per line in binary
00000000_01000000_00000000_00000000
00000000_00111000_01111010_11010100
00000000_00110001_11010111_11011111
00000000_00101011_11111100_10001100
00000000_00100110_11010001_01100110
00000000_00100010_01000001_10111001
00000000_00011110_00111011_01000001
00000000_00011010_10101101_11011110

/* tb/tb_fixed_point_exp.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fixed_point_exp import exp_pkg::*; ();

    localparam int        EVAL_COUNT  = 200;  // 183 evaluations below, rounded up
    localparam int        CYCLE_LIMIT = 20 * EVAL_COUNT + 100;
    localparam int        WAIT_LIMIT  = 20;   // edges allowed for one ready pulse
    localparam exp_word_t SAT_MASK    = 32'h7C00_0000;

    logic      clk;
    logic      reset;
    logic      start_exp;
    exp_word_t x;
    exp_word_t exp_out_reg;
    logic      softmax_output_ready;

    exp_word_t lut_1_model [0:15];
    exp_word_t lut_2_model [0:7];

    int        error_count;
    int        check_count;
    int        cycle_count = 0;
    int        launch_cycle;  // cycle count just after the start edge
    integer    seed;

    fixed_point_exp i_dut (
        .clk                  (clk),
        .reset                (reset),
        .start_exp            (start_exp),
        .x                    (x),
        .exp_out_reg          (exp_out_reg),
        .softmax_output_ready (softmax_output_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model, Q10.22 rules
    function automatic exp_word_t fixed_mul(input exp_word_t a, input exp_word_t b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        return prod[FRACTION +: DATA_WIDTH];  // truncated
    endfunction

    function automatic exp_word_t expected_exp(input exp_word_t arg);
        exp_arg_u  a;
        exp_word_t r;
        exp_word_t neg_r;
        exp_word_t one_minus_r;
        exp_word_t sq;
        exp_word_t cube;
        exp_word_t half_sq;
        exp_word_t two_half;
        exp_word_t neg_cube;
        exp_word_t poly;
        exp_word_t p12;
        a = arg;
        if (a.f.sat != 5'd0)
            return '0;
        r           = exp_word_t'(a.f.rem);
        neg_r       = ~r + 32'd1;
        one_minus_r = ONE + neg_r;
        sq          = fixed_mul(r, r);
        cube        = fixed_mul(r, sq);
        half_sq     = one_minus_r + (sq >> 1);
        two_half    = (cube << 1) + (cube >> 1);  // 2.5 r^3
        neg_cube    = ~(two_half >> 4) + 32'd1;
        poly        = half_sq + neg_cube;
        p12         = fixed_mul(lut_1_model[a.f.int_idx], lut_2_model[a.f.frac_idx]);
        return fixed_mul(p12, poly);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks
    task automatic check_word(input string name, input exp_word_t got,
                              input exp_word_t expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    task automatic check_latency(input int latency, input int expected);
        check_count++;
        if ((latency >= 0) && (latency != expected))
            note_failure($sformatf("ready came %0d cycles after start instead of %0d",
                                   latency, expected));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus, all tasks start and end just after a falling edge
    task automatic launch(input exp_word_t arg);
        x         = arg;
        start_exp = 1'b1;
        @(negedge clk);
        start_exp    = 1'b0;
        launch_cycle = cycle_count;
    endtask

    task automatic wait_ready(output int latency);
        while (!softmax_output_ready && ((cycle_count - launch_cycle) < WAIT_LIMIT))
            @(negedge clk);
        if (softmax_output_ready)
            latency = cycle_count - launch_cycle;
        else
        begin
            latency = -1;
            note_failure($sformatf("ready never rose within %0d cycles of start",
                                   WAIT_LIMIT));
        end
    endtask

    // stops on the cycle where ready is high
    task automatic run_to_ready(input exp_word_t arg);
        exp_arg_u a;
        int       latency;
        a = arg;
        launch(arg);
        wait_ready(latency);
        check_latency(latency, (a.f.sat != 5'd0) ? 1 : 7);
        check_word("exp_out_reg", exp_out_reg, expected_exp(arg));
    endtask

    task automatic check_hold(input int cycles, input exp_word_t held);
        repeat (cycles)
        begin
            @(negedge clk);
            check_bit("softmax_output_ready", softmax_output_ready, 1'b0);
            check_word("exp_out_reg", exp_out_reg, held);
        end
    endtask

    task automatic evaluate(input exp_word_t arg);
        run_to_ready(arg);
        check_hold(1, expected_exp(arg));  // pulse is one cycle, result held
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    task automatic test_reset_state();
        check_bit("softmax_output_ready", softmax_output_ready, 1'b0);
        check_word("exp_out_reg", exp_out_reg, '0);
    endtask

    task automatic test_table_sweep();
        exp_arg_u a;
        evaluate(32'h0000_0000);
        evaluate(32'h0000_0001);
        evaluate(32'h0000_1234);
        evaluate(32'h0007_FFFF);  // largest remainder
        for (int i = 0; i < 16; i++)
        begin
            for (int j = 0; j < 8; j++)
            begin
                a            = '0;
                a.f.int_idx  = i[3:0];
                a.f.frac_idx = j[2:0];
                a.f.rem      = 19'h15555;
                evaluate(a.raw);
            end
        end
    endtask

    task automatic test_saturation();
        evaluate(32'h0040_0000);  // nonzero result first
        for (int b = 0; b < 5; b++)
            evaluate((exp_word_t'(1) << (26 + b)) | 32'h0012_3456);
        evaluate(32'hFFFF_FFFF);
    endtask

    task automatic test_capture();
        exp_word_t first;
        int        latency;
        first = 32'h00A5_4321;
        launch(first);
        repeat (4)
        begin
            x         = $random(seed);  // busy, so neither is taken
            start_exp = 1'b1;
            @(negedge clk);
        end
        start_exp = 1'b0;
        wait_ready(latency);
        check_latency(latency, 7);
        check_word("exp_out_reg", exp_out_reg, expected_exp(first));
        check_hold(8, expected_exp(first));  // no second pulse
    endtask

    task automatic test_back_to_back();
        run_to_ready(32'h0123_4567);
        run_to_ready(32'h0800_0000);  // saturated, started off ready
        run_to_ready(32'h8156_789A);
        check_hold(6, expected_exp(32'h8156_789A));
    endtask

    task automatic test_random();
        exp_word_t value;
        repeat (40)
        begin
            value = $random(seed);
            value = value & ~SAT_MASK;
            evaluate(value);
        end
    endtask

    initial
    begin
        error_count = 0;
        check_count = 0;
        seed        = 55507;
        reset       = 1'b1;
        start_exp   = 1'b0;
        x           = '0;
        $readmemb(LUT_1_FILE, lut_1_model);
        $readmemb(LUT_2_FILE, lut_2_model);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_table_sweep();
        test_saturation();
        test_capture();
        test_back_to_back();
        test_random();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fixed_point_exp.sv */
`timescale 1ns/100ps
`default_nettype none

module fixed_point_exp import exp_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_exp,
    input  exp_word_t x,
    output exp_word_t exp_out_reg,
    output logic      softmax_output_ready
);

    exp_arg_u   x_arg;
    logic [3:0] int_idx;
    logic [2:0] frac_idx;
    exp_word_t  p1;
    exp_word_t  p2;

    assign x_arg = x;  // field view of the live input

    exp_ctrl_if bus ();

    // sat is checked on the live word, the rest works on the captured copy
    exp_controller i_ctrl (
        .clk       (clk),
        .reset     (reset),
        .start_exp (start_exp),
        .arg_sat   (x_arg.f.sat),
        .bus       (bus.ctrl),
        .ready     (softmax_output_ready)
    );

    exp_datapath i_dp (
        .clk      (clk),
        .reset    (reset),
        .x        (x_arg),
        .bus      (bus.dp),
        .p1       (p1),
        .p2       (p2),
        .int_idx  (int_idx),
        .frac_idx (frac_idx),
        .result   (exp_out_reg)
    );

    exp_lut_rom i_rom (
        .int_idx  (int_idx),
        .frac_idx (frac_idx),
        .p1       (p1),
        .p2       (p2)
    );

endmodule

`default_nettype wire

/* verilog/exp_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module exp_datapath import exp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  exp_arg_u   x,
    exp_ctrl_if.dp     bus,
    input  exp_word_t  p1,
    input  exp_word_t  p2,
    output logic [3:0] int_idx,
    output logic [2:0] frac_idx,
    output exp_word_t  result
);

    exp_arg_u  arg_q;  // argument taken at start
    exp_word_t r;      // low remainder as a full word

    // partial results
    exp_word_t p12_q;          // P1*P2
    exp_word_t neg_r_q;        // -r
    exp_word_t one_minus_r_q;  // 1-r
    exp_word_t sq_q;           // r^2
    exp_word_t cube_q;         // r^3
    exp_word_t half_sq_q;      // 1-r+r^2/2
    exp_word_t two_half_q;     // 2.5*r^3
    exp_word_t neg_cube_q;     // -2.5*r^3/16
    exp_word_t poly_q;         // full polynomial

    exp_word_t                  mul_a;
    exp_word_t                  mul_b;
    logic [2*DATA_WIDTH-1:0]    mul_full;
    exp_word_t                  mul_out;
    exp_word_t                  add_a;
    exp_word_t                  add_b;
    exp_word_t                  add_out;

    always_ff @(posedge clk)
    begin
        if (bus.capture)
            arg_q <= x;
    end

    assign int_idx  = arg_q.f.int_idx;
    assign frac_idx = arg_q.f.frac_idx;
    assign r        = {{(DATA_WIDTH-REM_WIDTH){1'b0}}, arg_q.f.rem};

    ////////////////////////////////////////////////////////////////////
    // shared multiplier
    always_comb
    begin
        case (bus.mul_op)
            MUL_P1_P2:        mul_a = p1;
            MUL_R_R, MUL_R_SQ: mul_a = r;
            default:          mul_a = p12_q;
        endcase
        case (bus.mul_op)
            MUL_P1_P2: mul_b = p2;
            MUL_R_R:   mul_b = r;
            MUL_R_SQ:  mul_b = sq_q;
            default:   mul_b = poly_q;
        endcase
    end

    assign mul_full = (2*DATA_WIDTH)'(mul_a) * (2*DATA_WIDTH)'(mul_b);  // unsigned 64 bit
    assign mul_out  = mul_full[FRACTION +: DATA_WIDTH];  // drop low fraction

    ////////////////////////////////////////////////////////////////////
    // shared adder with logical shifts
    always_comb
    begin
        case (bus.add_op)
            ADD_NEG_R:         add_a = ~r;
            ADD_ONE_MINUS_R:   add_a = ONE;
            ADD_HALF_SQ:       add_a = one_minus_r_q;
            ADD_TWO_HALF_CUBE: add_a = cube_q << 1;
            ADD_NEG_CUBE_TERM: add_a = ~(two_half_q >> 4);
            default:           add_a = half_sq_q;
        endcase
        case (bus.add_op)
            ADD_NEG_R,
            ADD_NEG_CUBE_TERM: add_b = exp_word_t'(1);  // two's complement
            ADD_ONE_MINUS_R:   add_b = neg_r_q;
            ADD_HALF_SQ:       add_b = sq_q >> 1;
            ADD_TWO_HALF_CUBE: add_b = cube_q >> 1;
            default:           add_b = neg_cube_q;
        endcase
    end

    assign add_out = add_a + add_b;  // wraps at 32 bits

    ////////////////////////////////////////////////////////////////////
    // destination register follows from the op code
    always_ff @(posedge clk)
    begin
        if (bus.mul_en)
        begin
            case (bus.mul_op)
                MUL_P1_P2: p12_q  <= mul_out;
                MUL_R_R:   sq_q   <= mul_out;
                MUL_R_SQ:  cube_q <= mul_out;
                default:   ;  // final product goes to result below
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.add_en)
        begin
            case (bus.add_op)
                ADD_NEG_R:         neg_r_q       <= add_out;
                ADD_ONE_MINUS_R:   one_minus_r_q <= add_out;
                ADD_HALF_SQ:       half_sq_q     <= add_out;
                ADD_TWO_HALF_CUBE: two_half_q    <= add_out;
                ADD_NEG_CUBE_TERM: neg_cube_q    <= add_out;
                default:           poly_q        <= add_out;
            endcase
        end
    end

    // held until the next evaluation
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            result <= '0;
        else if (bus.clear_result)
            result <= '0;
        else if (bus.mul_en && (bus.mul_op == MUL_P12_POLY))
            result <= mul_out;
    end

endmodule

`default_nettype wire

/* verilog/exp_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module exp_controller import exp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_exp,
    input  logic [4:0] arg_sat,
    exp_ctrl_if.ctrl   bus,
    output logic       ready
);

    exp_state_e state;
    exp_state_e next_state;
    logic       accept;  // a start is taken this cycle

    // start only counts in IDLE or on the last ready cycle
    assign accept = start_exp && ((state == IDLE) || (state == READY));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    always_comb
    begin
        next_state = state;
        case (state)
            IDLE, READY:
            begin
                if (accept && (arg_sat != 5'd0))
                    next_state = SATURATE;
                else if (accept)
                    next_state = P12_NEG;
                else
                    next_state = IDLE;
            end
            P12_NEG:      next_state = SQ_ONE_MINUS;
            SQ_ONE_MINUS: next_state = CUBE_HALF_SQ;
            CUBE_HALF_SQ: next_state = TWO_HALF;
            TWO_HALF:     next_state = NEG_CUBE;
            NEG_CUBE:     next_state = POLY;
            POLY:         next_state = PRODUCT;
            PRODUCT:      next_state = READY;
            SATURATE:     next_state = READY;
            default:      next_state = IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // step schedule, one multiply and/or one add per state
    always_comb
    begin
        bus.capture      = accept;
        bus.mul_en       = 1'b0;
        bus.mul_op       = MUL_P1_P2;
        bus.add_en       = 1'b0;
        bus.add_op       = ADD_NEG_R;
        bus.clear_result = 1'b0;
        case (state)
            P12_NEG:
            begin
                bus.mul_en = 1'b1;  // P1*P2
                bus.add_en = 1'b1;  // -r
            end
            SQ_ONE_MINUS:
            begin
                bus.mul_en = 1'b1;
                bus.mul_op = MUL_R_R;
                bus.add_en = 1'b1;
                bus.add_op = ADD_ONE_MINUS_R;
            end
            CUBE_HALF_SQ:
            begin
                bus.mul_en = 1'b1;
                bus.mul_op = MUL_R_SQ;
                bus.add_en = 1'b1;
                bus.add_op = ADD_HALF_SQ;
            end
            TWO_HALF:
            begin
                bus.add_en = 1'b1;
                bus.add_op = ADD_TWO_HALF_CUBE;
            end
            NEG_CUBE:
            begin
                bus.add_en = 1'b1;
                bus.add_op = ADD_NEG_CUBE_TERM;
            end
            POLY:
            begin
                bus.add_en = 1'b1;
                bus.add_op = ADD_POLY_SUM;
            end
            PRODUCT:
            begin
                bus.mul_en = 1'b1;  // final product into the result
                bus.mul_op = MUL_P12_POLY;
            end
            SATURATE: bus.clear_result = 1'b1;
            default:  ;
        endcase
    end

    assign ready = (state == READY);  // single cycle, not held

endmodule

`default_nettype wire

/* verilog/exp_lut_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module exp_lut_rom import exp_pkg::*;
(
    input  logic [3:0] int_idx,
    input  logic [2:0] frac_idx,
    output exp_word_t  p1,
    output exp_word_t  p2
);

    exp_word_t lut_1 [0:15];  // coarse integer steps
    exp_word_t lut_2 [0:7];   // eighth steps

    // contents come from binary text files at elaboration
    initial
    begin
        $readmemb(LUT_1_FILE, lut_1);
        $readmemb(LUT_2_FILE, lut_2);
    end

    // plain combinational read, no latency
    assign p1 = lut_1[int_idx];
    assign p2 = lut_2[frac_idx];

endmodule

`default_nettype wire

/* verilog/exp_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

// per-cycle step commands from the sequencer to the datapath
interface exp_ctrl_if import exp_pkg::*; ();

    logic    capture;       // latch the argument
    logic    mul_en;
    mul_op_e mul_op;        // also picks the destination register
    logic    add_en;
    add_op_e add_op;
    logic    clear_result;  // saturated shortcut

    modport ctrl (
        output capture,
        output mul_en,
        output mul_op,
        output add_en,
        output add_op,
        output clear_result
    );

    modport dp (
        input capture,
        input mul_en,
        input mul_op,
        input add_en,
        input add_op,
        input clear_result
    );

endinterface

`default_nettype wire

/* verilog/exp_pkg.sv */
`default_nettype none

package exp_pkg;

    ////////////////////////////////////////////////////////////////////
    // word format, Q10.22
    localparam int DATA_WIDTH = 32;
    localparam int FRACTION   = 22;
    localparam int REM_WIDTH  = 19;  // bits below the table fields

    typedef logic [DATA_WIDTH-1:0] exp_word_t;

    localparam exp_word_t ONE = exp_word_t'(1) << FRACTION;

    // one argument word, seen raw or split into its fields
    typedef union packed {
        exp_word_t raw;
        struct packed {
            logic                 sign;      // ignored
            logic [4:0]           sat;       // any bit set forces zero
            logic [3:0]           int_idx;   // table 1
            logic [2:0]           frac_idx;  // table 2
            logic [REM_WIDTH-1:0] rem;       // polynomial part
        } f;
    } exp_arg_u;

    ////////////////////////////////////////////////////////////////////
    // shared unit steps
    typedef enum logic [1:0] {
        MUL_P1_P2    = 2'd0,
        MUL_R_R      = 2'd1,
        MUL_R_SQ     = 2'd2,
        MUL_P12_POLY = 2'd3
    } mul_op_e;

    typedef enum logic [2:0] {
        ADD_NEG_R         = 3'd0,
        ADD_ONE_MINUS_R   = 3'd1,
        ADD_HALF_SQ       = 3'd2,
        ADD_TWO_HALF_CUBE = 3'd3,
        ADD_NEG_CUBE_TERM = 3'd4,
        ADD_POLY_SUM      = 3'd5
    } add_op_e;

    // sequencer states, neighbours mostly one bit apart
    typedef enum logic [3:0] {
        IDLE         = 4'b0000,
        P12_NEG      = 4'b0001,
        SQ_ONE_MINUS = 4'b0011,
        CUBE_HALF_SQ = 4'b0010,
        TWO_HALF     = 4'b0110,
        NEG_CUBE     = 4'b0111,
        POLY         = 4'b0101,
        SATURATE     = 4'b0100,
        PRODUCT      = 4'b1100,
        READY        = 4'b1101
    } exp_state_e;

    localparam string LUT_1_FILE = "exp_lut_1.mem";  // e^(-k), k = 0..15
    localparam string LUT_2_FILE = "exp_lut_2.mem";  // e^(-k/8), k = 0..7

endpackage

`default_nettype wire
